// File: Bender.yml
package:
  name: hdmi_packet

sources:
  - include_dirs:
      - logic
    files:
      - logic/hdmi_pkt_pkg.sv
      - logic/pkt_apb_regs.sv
      - logic/audio_clock_regen_packet.sv
      - logic/audio_infoframe_packet.sv
      - logic/packet_scheduler.sv
      - logic/hdmi_packet_subsystem.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clocks.sv
      - tests/hdmi_packet_asserts.sv
      - tests/tb_hdmi_packet.sv

// File: filelist.f
+incdir+logic
logic/hdmi_pkt_pkg.sv
logic/pkt_apb_regs.sv
logic/audio_clock_regen_packet.sv
logic/audio_infoframe_packet.sv
logic/packet_scheduler.sv
logic/hdmi_packet_subsystem.sv
tests/tb_clocks.sv
tests/hdmi_packet_asserts.sv
tests/tb_hdmi_packet.sv

// File: logic/audio_clock_regen_packet.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// audio clock regeneration packet
// divides clk_audio by n/128 and measures cts in pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module audio_clock_regen_packet
(
    input  logic                            clk_pixel,
    input  logic                            clk_audio,
    input  logic                            reset,
    input  logic                            acr_en,
    input  logic [`HDMI_PKT_N_WIDTH-1:0]    acr_n,
    output logic                            cts_fresh,
    output logic [23:0]                     acr_header,
    output logic [55:0]                     acr_sub0,
    output logic [55:0]                     acr_sub1,
    output logic [55:0]                     acr_sub2,
    output logic [55:0]                     acr_sub3
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // audio domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [1:0]                         audio_rst_sync;
    logic [1:0]                         audio_en_sync;
    logic [`HDMI_PKT_DIV_WIDTH-1:0]     div_count;
    logic [`HDMI_PKT_DIV_WIDTH-1:0]     div_last;
    logic                               wrap_toggle;

    always_ff @(posedge clk_audio)
    begin
        audio_rst_sync <= {audio_rst_sync[0], reset};
    end

    // n/128, last count is one below that
    assign div_last = acr_n[`HDMI_PKT_N_WIDTH-1:`HDMI_PKT_N_WIDTH-`HDMI_PKT_DIV_WIDTH] - 1'b1;

    always_ff @(posedge clk_audio)
    begin
        if (audio_rst_sync[1])
        begin
            audio_en_sync <= 2'b00;
            div_count     <= '0;
            wrap_toggle   <= 1'b0;
        end
        else
        begin
            audio_en_sync <= {audio_en_sync[0], acr_en};
            if (!audio_en_sync[1])
            begin
                div_count <= '0;
            end
            else if (div_count == div_last)
            begin
                div_count   <= '0;
                wrap_toggle <= ~wrap_toggle;
            end
            else
            begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [2:0]                         wrap_sync;
    logic                               wrap_seen;
    logic                               primed;
    logic [`HDMI_PKT_CTS_WIDTH-1:0]     cts_count;
    logic [`HDMI_PKT_N_WIDTH-1:0]       cts;

    // [1:0] synchronizer, [2] edge detect
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            wrap_sync <= 3'b000;
        end
        else
        begin
            wrap_sync <= {wrap_sync[1:0], wrap_toggle};
        end
    end

    assign wrap_seen = wrap_sync[2] ^ wrap_sync[1];

    // first wrap after enable spans a partial period, so it only primes
    always_ff @(posedge clk_pixel)
    begin
        if (reset || !acr_en)
        begin
            cts_count <= '0;
            primed    <= 1'b0;
            cts_fresh <= 1'b0;
        end
        else
        begin
            cts_fresh <= wrap_seen & primed;
            if (wrap_seen)
            begin
                cts_count <= 1;
                primed    <= 1'b1;
            end
            else if (cts_count != '1)
            begin
                cts_count <= cts_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (wrap_seen)
        begin
            cts <= cts_count;
        end
    end

    // type 1, bytes 1 and 2 are don't-care for the sink
    assign acr_header = {8'd0, 8'd0, 8'd1};

    // all four subpackets identical
    assign acr_sub0 = {acr_n[7:0], acr_n[15:8], {4'd0, acr_n[19:16]},
                       cts[7:0], cts[15:8], {4'd0, cts[19:16]}, 8'd0};
    assign acr_sub1 = acr_sub0;
    assign acr_sub2 = acr_sub0;
    assign acr_sub3 = acr_sub0;

endmodule

// File: logic/audio_infoframe_packet.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// audio infoframe packet
// fixed header, programmed fields, checksum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module audio_infoframe_packet
(
    input  logic [`HDMI_PKT_AIF_CC_WIDTH-1:0]   aif_channels,
    input  logic [`HDMI_PKT_AIF_CT_WIDTH-1:0]   aif_coding,
    input  logic [`HDMI_PKT_AIF_SF_WIDTH-1:0]   aif_freq,
    output logic [23:0]                         aif_header,
    output logic [55:0]                         aif_sub0,
    output logic [55:0]                         aif_sub1,
    output logic [55:0]                         aif_sub2,
    output logic [55:0]                         aif_sub3
);

    // infoframe type, version, length
    localparam logic [7:0] hb0 = 8'h84;
    localparam logic [7:0] hb1 = 8'h01;
    localparam logic [7:0] hb2 = 8'h0A;

    logic [7:0] pb1;
    logic [7:0] pb2;
    logic [7:0] byte_sum;
    logic [7:0] checksum;

    // coding type in upper nibble, channel count in low bits
    assign pb1 = {aif_coding, 1'b0, aif_channels};

    // sample frequency code at bits 4:2
    assign pb2 = {3'd0, aif_freq, 2'd0};

    // everything else in the payload is zero, so only these
    // five bytes contribute to the sum
    assign byte_sum = hb0 + hb1 + hb2 + pb1 + pb2;
    assign checksum = 8'd0 - byte_sum;

    assign aif_header = {hb2, hb1, hb0};

    // pb6 down to pb0, checksum in the low byte
    assign aif_sub0 = {8'd0, 8'd0, 8'd0, 8'd0, pb2, pb1, checksum};
    assign aif_sub1 = '0;
    assign aif_sub2 = '0;
    assign aif_sub3 = '0;

endmodule

// File: logic/hdmi_packet_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hdmi data island packet source, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module hdmi_packet_subsystem
    import hdmi_pkt_pkg::*;
(
    input  logic            clk_pixel,
    input  logic            clk_audio,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [7:0]      paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    input  logic            island_req,
    input  logic            pkt_ready,
    output logic            pkt_valid,
    output packet_kind_e    pkt_kind,
    output logic [23:0]     pkt_header,
    output logic [55:0]     pkt_sub0,
    output logic [55:0]     pkt_sub1,
    output logic [55:0]     pkt_sub2,
    output logic [55:0]     pkt_sub3
);

    logic                               acr_en;
    logic                               aif_en;
    logic [`HDMI_PKT_N_WIDTH-1:0]       acr_n;
    logic [`HDMI_PKT_AIF_CC_WIDTH-1:0]  aif_channels;
    logic [`HDMI_PKT_AIF_CT_WIDTH-1:0]  aif_coding;
    logic [`HDMI_PKT_AIF_SF_WIDTH-1:0]  aif_freq;
    logic                               cts_fresh;
    logic [23:0]                        acr_header;
    logic [55:0]                        acr_sub0, acr_sub1, acr_sub2, acr_sub3;
    logic [23:0]                        aif_header;
    logic [55:0]                        aif_sub0, aif_sub1, aif_sub2, aif_sub3;

    pkt_apb_regs i_pkt_apb_regs (
        .clk_pixel, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .acr_en, .aif_en, .acr_n,
        .aif_channels, .aif_coding, .aif_freq
    );

    audio_clock_regen_packet i_audio_clock_regen_packet (
        .clk_pixel, .clk_audio, .reset,
        .acr_en, .acr_n, .cts_fresh, .acr_header,
        .acr_sub0, .acr_sub1, .acr_sub2, .acr_sub3
    );

    audio_infoframe_packet i_audio_infoframe_packet (
        .aif_channels, .aif_coding, .aif_freq, .aif_header,
        .aif_sub0, .aif_sub1, .aif_sub2, .aif_sub3
    );

    packet_scheduler i_packet_scheduler (
        .clk_pixel, .reset, .island_req, .pkt_ready,
        .acr_en, .aif_en, .cts_fresh,
        .acr_header, .acr_sub0, .acr_sub1, .acr_sub2, .acr_sub3,
        .aif_header, .aif_sub0, .aif_sub1, .aif_sub2, .aif_sub3,
        .pkt_valid, .pkt_kind, .pkt_header,
        .pkt_sub0, .pkt_sub1, .pkt_sub2, .pkt_sub3
    );

endmodule

// File: logic/hdmi_pkt_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hdmi packet source configuration
// register offsets, field widths and positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HDMI_PKT_CFG_SVH
`define HDMI_PKT_CFG_SVH

// apb register offsets, one 32-bit word each
`define HDMI_PKT_REG_CTRL  8'h00
`define HDMI_PKT_REG_ACR_N 8'h04
`define HDMI_PKT_REG_AIF   8'h08

// n, cts and the n/128 divider
`define HDMI_PKT_N_WIDTH   20
`define HDMI_PKT_DIV_WIDTH 13
`define HDMI_PKT_CTS_WIDTH 20

// audio infoframe fields in the AIF register
`define HDMI_PKT_AIF_CC_WIDTH 3
`define HDMI_PKT_AIF_CT_WIDTH 4
`define HDMI_PKT_AIF_SF_WIDTH 3
`define HDMI_PKT_AIF_CC_LSB   0
`define HDMI_PKT_AIF_CT_LSB   3
`define HDMI_PKT_AIF_SF_LSB   7

`endif

// File: logic/hdmi_pkt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hdmi packet source types
// packet kinds, scheduler states, register select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hdmi_pkt_pkg;

    // which packet sits on the scheduler output
    typedef enum logic [1:0]
    {
        PKT_NULL = 2'd0,
        PKT_ACR  = 2'd1,
        PKT_AIF  = 2'd2
    } packet_kind_e;

    // scheduler fsm
    // idle waits for an island, load latches the choice,
    // hold presents it until the transfer
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_HOLD = 2'd2
    } sched_state_e;

    // decoded apb register target
    typedef enum logic [1:0]
    {
        REG_SEL_CTRL  = 2'd0,
        REG_SEL_ACR_N = 2'd1,
        REG_SEL_AIF   = 2'd2,
        REG_SEL_NONE  = 2'd3
    } reg_sel_e;

endpackage

// File: logic/packet_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data island packet scheduler
// picks acr, infoframe or null and holds it for ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module packet_scheduler
    import hdmi_pkt_pkg::*;
(
    input  logic            clk_pixel,
    input  logic            reset,
    input  logic            island_req,
    input  logic            pkt_ready,
    input  logic            acr_en,
    input  logic            aif_en,
    input  logic            cts_fresh,
    input  logic [23:0]     acr_header,
    input  logic [55:0]     acr_sub0,
    input  logic [55:0]     acr_sub1,
    input  logic [55:0]     acr_sub2,
    input  logic [55:0]     acr_sub3,
    input  logic [23:0]     aif_header,
    input  logic [55:0]     aif_sub0,
    input  logic [55:0]     aif_sub1,
    input  logic [55:0]     aif_sub2,
    input  logic [55:0]     aif_sub3,
    output logic            pkt_valid,
    output packet_kind_e    pkt_kind,
    output logic [23:0]     pkt_header,
    output logic [55:0]     pkt_sub0,
    output logic [55:0]     pkt_sub1,
    output logic [55:0]     pkt_sub2,
    output logic [55:0]     pkt_sub3
);

    sched_state_e state;
    sched_state_e state_next;
    packet_kind_e kind_next;
    logic         cts_pending;
    logic         transfer;

    assign pkt_valid = (state == ST_HOLD);
    assign transfer  = pkt_valid & pkt_ready;

    always_comb
    begin
        state_next = state;
        unique case (state)
            // requests outside idle are dropped
            ST_IDLE: if (island_req) state_next = ST_LOAD;
            ST_LOAD: state_next = ST_HOLD;
            ST_HOLD: if (pkt_ready) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // a new cts wins over the clear of the acr just sent
    always_ff @(posedge clk_pixel)
    begin
        if (reset || !acr_en)
        begin
            cts_pending <= 1'b0;
        end
        else if (cts_fresh)
        begin
            cts_pending <= 1'b1;
        end
        else if (transfer && pkt_kind == PKT_ACR)
        begin
            cts_pending <= 1'b0;
        end
    end

    // priority: fresh cts, then infoframe, then null
    always_comb
    begin
        if (acr_en && cts_pending)
        begin
            kind_next = PKT_ACR;
        end
        else if (aif_en)
        begin
            kind_next = PKT_AIF;
        end
        else
        begin
            kind_next = PKT_NULL;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            pkt_kind <= PKT_NULL;
        end
        else if (state == ST_LOAD)
        begin
            pkt_kind <= kind_next;
        end
    end

    // payload, captured in load and frozen through hold
    always_ff @(posedge clk_pixel)
    begin
        if (state == ST_LOAD)
        begin
            unique case (kind_next)
                PKT_ACR:
                begin
                    pkt_header <= acr_header;
                    {pkt_sub3, pkt_sub2, pkt_sub1, pkt_sub0} <=
                        {acr_sub3, acr_sub2, acr_sub1, acr_sub0};
                end
                PKT_AIF:
                begin
                    pkt_header <= aif_header;
                    {pkt_sub3, pkt_sub2, pkt_sub1, pkt_sub0} <=
                        {aif_sub3, aif_sub2, aif_sub1, aif_sub0};
                end
                default:
                begin
                    pkt_header <= '0;
                    {pkt_sub3, pkt_sub2, pkt_sub1, pkt_sub0} <= '0;
                end
            endcase
        end
    end

endmodule

// File: logic/pkt_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register block for the packet source
// control, acr n and audio infoframe fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module pkt_apb_regs
    import hdmi_pkt_pkg::*;
(
    input  logic                                clk_pixel,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [7:0]                          paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                acr_en,
    output logic                                aif_en,
    output logic [`HDMI_PKT_N_WIDTH-1:0]        acr_n,
    output logic [`HDMI_PKT_AIF_CC_WIDTH-1:0]   aif_channels,
    output logic [`HDMI_PKT_AIF_CT_WIDTH-1:0]   aif_coding,
    output logic [`HDMI_PKT_AIF_SF_WIDTH-1:0]   aif_freq
);

    reg_sel_e reg_sel;
    logic     wr_strobe;

    // address decode
    always_comb
    begin
        unique case (paddr)
            `HDMI_PKT_REG_CTRL:  reg_sel = REG_SEL_CTRL;
            `HDMI_PKT_REG_ACR_N: reg_sel = REG_SEL_ACR_N;
            `HDMI_PKT_REG_AIF:   reg_sel = REG_SEL_AIF;
            default:             reg_sel = REG_SEL_NONE;
        endcase
    end

    // one wait state: low in first access cycle, high in second
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            pready <= 1'b0;
        end
        else
        begin
            pready <= psel & penable & ~pready;
        end
    end

    assign pslverr   = pready & (reg_sel == REG_SEL_NONE);
    assign wr_strobe = psel & penable & pready & pwrite;

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            acr_en       <= 1'b0;
            aif_en       <= 1'b0;
            acr_n        <= '0;
            aif_channels <= '0;
            aif_coding   <= '0;
            aif_freq     <= '0;
        end
        else if (wr_strobe)
        begin
            unique case (reg_sel)
                REG_SEL_CTRL:
                begin
                    acr_en <= pwdata[0];
                    aif_en <= pwdata[1];
                end
                // n must only change while acr_en is low
                REG_SEL_ACR_N: acr_n <= pwdata[`HDMI_PKT_N_WIDTH-1:0];
                REG_SEL_AIF:
                begin
                    aif_channels <= pwdata[`HDMI_PKT_AIF_CC_LSB +: `HDMI_PKT_AIF_CC_WIDTH];
                    aif_coding   <= pwdata[`HDMI_PKT_AIF_CT_LSB +: `HDMI_PKT_AIF_CT_WIDTH];
                    aif_freq     <= pwdata[`HDMI_PKT_AIF_SF_LSB +: `HDMI_PKT_AIF_SF_WIDTH];
                end
                default: ;
            endcase
        end
    end

    // read back, unknown offsets read zero
    always_comb
    begin
        prdata = '0;
        unique case (reg_sel)
            REG_SEL_CTRL:  prdata[1:0] = {aif_en, acr_en};
            REG_SEL_ACR_N: prdata[`HDMI_PKT_N_WIDTH-1:0] = acr_n;
            REG_SEL_AIF:
            begin
                prdata[`HDMI_PKT_AIF_CC_LSB +: `HDMI_PKT_AIF_CC_WIDTH] = aif_channels;
                prdata[`HDMI_PKT_AIF_CT_LSB +: `HDMI_PKT_AIF_CT_WIDTH] = aif_coding;
                prdata[`HDMI_PKT_AIF_SF_LSB +: `HDMI_PKT_AIF_SF_WIDTH] = aif_freq;
            end
            default: ;
        endcase
    end

endmodule

// File: tests/hdmi_packet_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet source checker, bound to the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module hdmi_packet_asserts
    import hdmi_pkt_pkg::*;
(
    input logic         clk_pixel,
    input logic         reset,
    input logic         psel,
    input logic         penable,
    input logic         pwrite,
    input logic [7:0]   paddr,
    input logic [31:0]  pwdata,
    input logic         pready,
    input logic         pslverr,
    input logic         island_req,
    input logic         pkt_ready,
    input logic         pkt_valid,
    input packet_kind_e pkt_kind,
    input logic [23:0]  pkt_header,
    input logic [55:0]  pkt_sub0,
    input logic [55:0]  pkt_sub1,
    input logic [55:0]  pkt_sub2,
    input logic [55:0]  pkt_sub3
);

    int          error_count = 0;
    logic [19:0] n_snoop;
    logic [2:0]  cc_snoop;
    logic [3:0]  ct_snoop;
    logic [2:0]  sf_snoop;
    logic        busy;
    logic [19:0] cts_field;
    logic [21:0] cts_ideal;
    logic [7:0]  aif_sum;
    logic        acr_ok;
    logic        aif_ok;

    // register values seen on completed apb writes
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            n_snoop  <= '0;
            cc_snoop <= '0;
            ct_snoop <= '0;
            sf_snoop <= '0;
        end
        else if (psel && penable && pready && pwrite)
        begin
            if (paddr == `HDMI_PKT_REG_ACR_N)
            begin
                n_snoop <= pwdata[19:0];
            end
            if (paddr == `HDMI_PKT_REG_AIF)
            begin
                cc_snoop <= pwdata[`HDMI_PKT_AIF_CC_LSB +: 3];
                ct_snoop <= pwdata[`HDMI_PKT_AIF_CT_LSB +: 4];
                sf_snoop <= pwdata[`HDMI_PKT_AIF_SF_LSB +: 3];
            end
        end
    end

    // scheduler busy from the request until the transfer
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            busy <= 1'b0;
        end
        else if (island_req && !busy)
        begin
            busy <= 1'b1;
        end
        else if (pkt_valid && pkt_ready)
        begin
            busy <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected packet content
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cts_field = {pkt_sub0[11:8], pkt_sub0[23:16], pkt_sub0[31:24]};
    assign cts_ideal = (22'(n_snoop) * 22'd3) >> 7;

    assign acr_ok = (pkt_header == 24'h000001) && (pkt_sub1 == pkt_sub0)
        && (pkt_sub2 == pkt_sub0) && (pkt_sub3 == pkt_sub0)
        && (pkt_sub0[7:0] == 8'd0) && (pkt_sub0[15:12] == 4'd0)
        && (pkt_sub0[39:36] == 4'd0)
        && ({pkt_sub0[35:32], pkt_sub0[47:40], pkt_sub0[55:48]} == n_snoop)
        && (22'(cts_field) + 22'd1 >= cts_ideal) && (22'(cts_field) <= cts_ideal + 22'd1);

    // header, checksum and payload bytes must sum to zero
    assign aif_sum = pkt_header[7:0] + pkt_header[15:8] + pkt_header[23:16]
        + pkt_sub0[7:0] + pkt_sub0[15:8] + pkt_sub0[23:16];

    assign aif_ok = (pkt_header == 24'h0A0184) && (aif_sum == 8'd0)
        && (pkt_sub0[15:12] == ct_snoop) && (pkt_sub0[11] == 1'b0)
        && (pkt_sub0[10:8] == cc_snoop) && (pkt_sub0[23:16] == {3'd0, sf_snoop, 2'd0})
        && (pkt_sub0[55:24] == '0) && (pkt_sub1 == '0)
        && (pkt_sub2 == '0) && (pkt_sub3 == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_pready_wait: assert property (@(posedge clk_pixel) disable iff (reset)
        (psel && $rose(penable)) |-> !pready ##1 pready)
        else begin error_count++; $error("pready not in second access cycle"); end

    // only the three defined offsets complete without an error
    a_pslverr_decode: assert property (@(posedge clk_pixel) disable iff (reset)
        (psel && penable && pready) |-> (pslverr == !(paddr inside
        {`HDMI_PKT_REG_CTRL, `HDMI_PKT_REG_ACR_N, `HDMI_PKT_REG_AIF})))
        else begin error_count++; $error("pslverr does not match the address"); end

    a_req_latency: assert property (@(posedge clk_pixel) disable iff (reset)
        (island_req && !busy) |=> !pkt_valid ##1 pkt_valid)
        else begin error_count++; $error("pkt_valid not 2 cycles after island_req"); end

    a_hold_stable: assert property (@(posedge clk_pixel) disable iff (reset)
        (pkt_valid && !pkt_ready) |=> pkt_valid && $stable(pkt_kind)
        && $stable(pkt_header) && $stable(pkt_sub0) && $stable(pkt_sub1)
        && $stable(pkt_sub2) && $stable(pkt_sub3))
        else begin error_count++; $error("packet changed under back-pressure"); end

    a_null_zero: assert property (@(posedge clk_pixel) disable iff (reset)
        (pkt_valid && pkt_kind == PKT_NULL) |-> (pkt_header == '0) && (pkt_sub0 == '0)
        && (pkt_sub1 == '0) && (pkt_sub2 == '0) && (pkt_sub3 == '0))
        else begin error_count++; $error("null packet not all zero"); end

    a_acr_content: assert property (@(posedge clk_pixel) disable iff (reset)
        (pkt_valid && pkt_kind == PKT_ACR) |-> acr_ok)
        else begin error_count++; $error("bad acr packet content"); end

    a_aif_content: assert property (@(posedge clk_pixel) disable iff (reset)
        (pkt_valid && pkt_kind == PKT_AIF) |-> aif_ok)
        else begin error_count++; $error("bad audio infoframe content"); end

endmodule

bind hdmi_packet_subsystem hdmi_packet_asserts i_hdmi_packet_asserts (.*);

// File: tests/tb_clocks.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clocks and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clocks
(
    output logic clk_pixel,
    output logic clk_audio,
    output logic reset
);

    // pixel clock, 40 ns
    initial
    begin
        clk_pixel = 1'b0;
        forever #20 clk_pixel = ~clk_pixel;
    end

    // audio clock, three pixel periods
    initial
    begin
        clk_audio = 1'b0;
        forever #60 clk_audio = ~clk_audio;
    end

    // reset high for 3 pixel cycles
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk_pixel);
        #1 reset = 1'b0;
    end

endmodule

// File: tests/tb_hdmi_packet.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the hdmi packet source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "hdmi_pkt_cfg.svh"

module tb_hdmi_packet
    import hdmi_pkt_pkg::*;
();

    localparam int  NUM_REQ = 84;
    localparam time TIMEOUT = NUM_REQ * 2000 + 50000;

    logic clk_pixel, clk_audio, reset;
    logic psel, penable, pwrite, pready, pslverr;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic island_req, pkt_ready, pkt_valid;
    packet_kind_e pkt_kind;
    logic [23:0] pkt_header;
    logic [55:0] pkt_sub0, pkt_sub1, pkt_sub2, pkt_sub3;

    integer seed;
    logic   aif_on;
    logic   fresh_flag, fresh_flag_d1, valid_prev;
    packet_kind_e last_kind;

    tb_clocks i_tb_clocks (.clk_pixel, .clk_audio, .reset);

    hdmi_packet_subsystem i_hdmi_packet_subsystem (.*);

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %h actual %h", test_name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_pixel);
        #1;
    endtask

    // setup cycle, then access until pready
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        cycles  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk_pixel);
        #1 penable = 1'b1;
        do
        begin
            @(posedge clk_pixel);
            #1 cycles++;
        end
        while (!pready && cycles < 8);
        if (!pready)
        begin
            $display("apb access at %h never completed", addr);
            stop_with_failure();
        end
        check_value("apb_wait_state", 32'd1, cycles);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_pixel);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic expect_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value("apb_write_pslverr", expect_err, err);
    endtask

    task automatic apb_read_check(input string test_name, input logic [7:0] addr,
                                  input logic [31:0] expected, input logic expect_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        check_value(test_name, expected, rdata);
        check_value({test_name, "_pslverr"}, expect_err, err);
    endtask

    // one island request, random ready stalls until the transfer
    task automatic send_packet(output packet_kind_e kind);
        int n;
        n = 0;
        island_req = 1'b1;
        @(posedge clk_pixel);
        #1 island_req = 1'b0;
        while (!pkt_valid && n < 10)
        begin
            wait_cycles(1);
            n++;
        end
        if (!pkt_valid)
        begin
            $display("no pkt_valid after island request");
            stop_with_failure();
        end
        n = 0;
        do
        begin
            pkt_ready = (($random(seed) & 3) != 0);
            kind = pkt_kind;
            wait_cycles(1);
            n++;
        end
        while (!pkt_ready && n < 100);
        if (!pkt_ready)
        begin
            $display("packet never transferred");
            stop_with_failure();
        end
        pkt_ready = 1'b0;
        wait_cycles(8 + ($unsigned($random(seed)) % 32));
    endtask

    // a cts that arrived after the last acr transfer
    always @(posedge clk_pixel)
    begin
        if (reset)
        begin
            fresh_flag    <= 1'b0;
            fresh_flag_d1 <= 1'b0;
            valid_prev    <= 1'b0;
            last_kind     <= PKT_NULL;
        end
        else
        begin
            if (pkt_valid && !valid_prev && last_kind == PKT_ACR && aif_on && !fresh_flag_d1)
            begin
                check_value("aif_after_acr", PKT_AIF, pkt_kind);
            end
            if (pkt_valid && pkt_ready)
            begin
                last_kind <= pkt_kind;
            end
            if (pkt_valid && pkt_ready && pkt_kind == PKT_ACR)
            begin
                fresh_flag <= i_hdmi_packet_subsystem.cts_fresh;
            end
            else
            begin
                fresh_flag <= fresh_flag | i_hdmi_packet_subsystem.cts_fresh;
            end
            fresh_flag_d1 <= fresh_flag;
            valid_prev    <= pkt_valid;
        end
    end

    always @(posedge clk_pixel)
    begin
        if (i_hdmi_packet_subsystem.i_hdmi_packet_asserts.error_count != 0)
        begin
            $display("a bound assertion failed");
            stop_with_failure();
        end
    end

    initial
    begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        stop_with_failure();
    end

    initial
    begin
        packet_kind_e kind;
        int acr_count;
        int aif_count;
        seed = 32'h355e_a6f2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        island_req = 1'b0;
        pkt_ready = 1'b0;
        aif_on = 1'b0;
        acr_count = 0;
        aif_count = 0;
        @(negedge reset);
        wait_cycles(1);
        check_value("reset_valid", 32'd0, pkt_valid);
        check_value("reset_pready", 32'd0, pready);

        // registers, including unknown offsets
        apb_read_check("ctrl_reset", `HDMI_PKT_REG_CTRL, 32'd0, 1'b0);
        apb_write(`HDMI_PKT_REG_ACR_N, 32'd6144, 1'b0);
        apb_read_check("acr_n", `HDMI_PKT_REG_ACR_N, 32'd6144, 1'b0);
        apb_write(`HDMI_PKT_REG_AIF, (32'd5 << 7) | (32'd9 << 3) | 32'd1, 1'b0);
        apb_read_check("aif", `HDMI_PKT_REG_AIF, (32'd5 << 7) | (32'd9 << 3) | 32'd1, 1'b0);
        apb_write(`HDMI_PKT_REG_CTRL, 32'd2, 1'b0);
        apb_read_check("ctrl", `HDMI_PKT_REG_CTRL, 32'd2, 1'b0);
        apb_write(`HDMI_PKT_REG_CTRL, 32'd0, 1'b0);
        apb_read_check("unknown_read", 8'h0C, 32'd0, 1'b1);
        apb_write(8'h10, 32'hFFFF_FFFF, 1'b1);
        apb_read_check("ctrl_after_unknown", `HDMI_PKT_REG_CTRL, 32'd0, 1'b0);

        // both enables off, null packets only
        repeat (4)
        begin
            send_packet(kind);
            check_value("null_kind", PKT_NULL, kind);
        end

        // acr only
        apb_write(`HDMI_PKT_REG_CTRL, 32'd1, 1'b0);
        repeat (40)
        begin
            send_packet(kind);
            if (kind == PKT_ACR)
            begin
                acr_count++;
            end
            else
            begin
                check_value("acr_phase_kind", PKT_NULL, kind);
            end
        end
        if (acr_count < 3)
        begin
            $display("too few acr packets with acr enabled");
            stop_with_failure();
        end

        // acr and infoframe together
        apb_write(`HDMI_PKT_REG_CTRL, 32'd3, 1'b0);
        aif_on = 1'b1;
        acr_count = 0;
        repeat (40)
        begin
            send_packet(kind);
            if (kind == PKT_ACR)
            begin
                acr_count++;
            end
            else
            begin
                check_value("mixed_phase_kind", PKT_AIF, kind);
                aif_count++;
            end
        end
        if (acr_count < 2 || aif_count < 5)
        begin
            $display("mixed phase did not carry both packet kinds");
            stop_with_failure();
        end

        if (i_hdmi_packet_subsystem.i_hdmi_packet_asserts.error_count == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            stop_with_failure();
        end
    end

endmodule
